/* Bender.yml */
package:
  name: ooo_frontend

sources:
  - source/ooo_pkg.sv
  - source/rename_if.sv
  - source/commit_if.sv
  - source/inst_decoder.sv
  - source/rename_regfile.sv
  - source/reorder_buffer.sv
  - source/ooo_frontend_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/ooo_frontend_tb.sv

/* ooo_frontend.f */
source/ooo_pkg.sv
source/rename_if.sv
source/commit_if.sv
source/inst_decoder.sv
source/rename_regfile.sv
source/reorder_buffer.sv
source/ooo_frontend_top.sv
sim/tb_clock.sv
sim/ooo_frontend_tb.sv

/* sim/ooo_frontend_tb.sv */
module ooo_frontend_tb import ooo_pkg::*;;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TAG_W = 3;
    localparam int DEPTH = 7;

    logic clk, rst, flush, instr_valid, instr_ready, wb_valid;
    logic [31:0] instr, pc, wb_data, dispatch_imm, dispatch_pc, rs1_data, rs2_data, commit_data;
    logic [TAG_W-1:0] wb_tag, dispatch_tag, rs1_tag, rs2_tag;
    logic [4:0] dispatch_rd, commit_rd;
    logic dispatch_valid, commit_valid;
    op_e dispatch_op;

    // driven instruction, as generated
    op_e cur_op;
    logic [4:0] cur_rd, cur_rs1, cur_rs2;
    logic [31:0] cur_imm;

    // reference model
    logic [31:0] mregs [32];
    logic [TAG_W-1:0] mtag [32];
    logic [4:0] rob_rd [8];
    logic [31:0] wbd [8];
    logic [TAG_W-1:0] q [$];
    logic [TAG_W-1:0] notdone [$];
    logic [TAG_W-1:0] next_tag;
    logic taken, d_pend, issue_en, wb_en;
    op_e d_op;
    logic [4:0] d_rd;
    logic [TAG_W-1:0] d_tag, d_s1t, d_s2t;
    logic [31:0] d_imm, d_pc, d_s1d, d_s2d;
    int err_val, err_other;

    tb_clock u_clk (.clk(clk));

    ooo_frontend_top #(.TAG_W(TAG_W)) uut (.*);

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            err_val++;
        end
    endtask

    task automatic new_instr();
        int kind;
        logic [4:0] rd, r1, r2;
        logic [11:0] imm;
        kind = $urandom % 8;
        rd = 5'($urandom % 8);
        r1 = 5'($urandom % 8);
        r2 = 5'($urandom % 8);
        imm = 12'($urandom);
        cur_rs1 <= r1;
        cur_rs2 <= (kind < 4 || kind == 6) ? r2 : 5'd0;
        cur_rd <= (kind < 6 && rd != 0) ? rd : 5'd0;
        cur_imm <= (kind >= 4 && kind <= 6) ? {{20{imm[11]}}, imm} : 32'd0;
        case (kind)
            0: begin
                instr <= {7'h00, r2, r1, 3'b000, rd, 7'b0110011};
                cur_op <= OP_ADD;
            end
            1: begin
                instr <= {7'h20, r2, r1, 3'b000, rd, 7'b0110011};
                cur_op <= OP_SUB;
            end
            2: begin
                instr <= {7'h00, r2, r1, 3'b111, rd, 7'b0110011};
                cur_op <= OP_AND;
            end
            3: begin
                instr <= {7'h00, r2, r1, 3'b110, rd, 7'b0110011};
                cur_op <= OP_OR;
            end
            4: begin
                instr <= {imm, r1, 3'b000, rd, 7'b0010011};
                cur_op <= OP_ADDI;
            end
            5: begin
                instr <= {imm, r1, 3'b010, rd, 7'b0000011};
                cur_op <= OP_LW;
            end
            6: begin
                instr <= {imm[11:5], r2, r1, 3'b010, imm[4:0], 7'b0100011};
                cur_op <= OP_SW;
            end
            default: begin
                instr <= {25'($urandom), 7'b1101111}; // jal, not supported
                cur_op <= OP_ILLEGAL;
                cur_rs1 <= 5'd0;
            end
        endcase
        pc <= {30'($urandom), 2'b00};
        instr_valid <= 1'b1;
    endtask

    // stimulus driver
    always @(posedge clk) begin
        int idx;
        if (!rst) begin
            if (!instr_valid || taken) begin
                if (issue_en && $urandom % 4 != 0) new_instr();
                else instr_valid <= 1'b0;
            end
            if (wb_en && notdone.size() > 0 && $urandom % 2 == 1) begin
                idx = $urandom % notdone.size();
                wb_tag <= notdone[idx];
                wb_data <= $urandom;
                wb_valid <= 1'b1;
                notdone.delete(idx);
            end else begin
                wb_valid <= 1'b0;
            end
        end
    end

    // model and checks, mid-cycle where everything is settled
    always @(negedge clk) begin
        logic [TAG_W-1:0] t;
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                mregs[i] = '0;
                mtag[i] = '0;
            end
            q.delete();
            notdone.delete();
            next_tag = 1;
            d_pend = 0;
            taken = 0;
        end else begin
            check_val("ready", 32'(q.size() - int'(commit_valid) < DEPTH), 32'(instr_ready));
            check_val("dispatch_valid", 32'(d_pend), 32'(dispatch_valid));
            if (d_pend && dispatch_valid) begin
                check_val("dispatch_op", 32'(d_op), 32'(dispatch_op));
                check_val("dispatch_rd", 32'(d_rd), 32'(dispatch_rd));
                check_val("dispatch_tag", 32'(d_tag), 32'(dispatch_tag));
                check_val("dispatch_imm", d_imm, dispatch_imm);
                check_val("dispatch_pc", d_pc, dispatch_pc);
                check_val("rs1_tag", 32'(d_s1t), 32'(rs1_tag));
                check_val("rs2_tag", 32'(d_s2t), 32'(rs2_tag));
                if (d_s1t == 0) check_val("rs1_data", d_s1d, rs1_data);
                if (d_s2t == 0) check_val("rs2_data", d_s2d, rs2_data);
            end
            d_pend = 0;
            taken = 0;
            if (flush) begin
                for (int i = 0; i < 32; i++) mtag[i] = '0;
                q.delete();
                notdone.delete();
                next_tag = 1; // pointers back to reset state
            end else begin
                if (wb_valid) wbd[wb_tag] = wb_data;
                if (commit_valid && q.size() == 0) begin
                    $display("commit seen with no outstanding instruction");
                    err_other++;
                end else if (commit_valid) begin
                    t = q.pop_front();
                    check_val("commit_rd", 32'(rob_rd[t]), 32'(commit_rd));
                    check_val("commit_data", wbd[t], commit_data);
                    if (rob_rd[t] != 0) begin
                        mregs[rob_rd[t]] = wbd[t];
                        if (mtag[rob_rd[t]] == t) mtag[rob_rd[t]] = '0;
                    end
                end
                if (instr_valid && instr_ready) begin
                    d_s1t = mtag[cur_rs1]; // read before rename
                    d_s2t = mtag[cur_rs2];
                    d_s1d = mregs[cur_rs1];
                    d_s2d = mregs[cur_rs2];
                    d_op = cur_op;
                    d_rd = cur_rd;
                    d_imm = cur_imm;
                    d_pc = pc;
                    d_tag = next_tag;
                    if (cur_rd != 0) mtag[cur_rd] = next_tag;
                    rob_rd[next_tag] = cur_rd;
                    q.push_back(next_tag);
                    notdone.push_back(next_tag);
                    next_tag = (next_tag == DEPTH) ? TAG_W'(1) : next_tag + 1'b1;
                    d_pend = 1;
                    taken = 1;
                end
            end
        end
    end

    a_flush_quiet: assert property (@(posedge clk) disable iff (rst)
        flush |=> !dispatch_valid && !commit_valid)
        else begin
            $display("dispatch or commit seen right after flush");
            err_other++;
        end

    task automatic wait_ready(input logic level, input string what);
        int n;
        n = 0;
        while (instr_ready !== level && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (n >= 100) begin
            $display("timeout waiting for %s", what);
            $display("TEST FAIL");
            $finish;
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((q.size() != 0 || instr_valid) && n < 300) begin
            @(posedge clk);
            n++;
        end
        if (n >= 300) begin
            $display("timeout waiting for the reorder buffer to drain");
            $display("TEST FAIL");
            $finish;
        end
    endtask

    initial begin
        void'($urandom(53));
        err_val = 0;
        err_other = 0;
        rst = 1'b1;
        flush = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        wb_valid = 1'b0;
        wb_tag = '0;
        wb_data = '0;
        issue_en = 1'b0;
        wb_en = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        issue_en <= 1'b1;
        wb_en <= 1'b1;
        repeat (300) @(posedge clk);
        wb_en <= 1'b0; // fill up the rob
        wait_ready(1'b0, "instr_ready to fall");
        repeat (5) @(posedge clk);
        wb_en <= 1'b1;
        wait_ready(1'b1, "instr_ready to rise");
        repeat (20) @(posedge clk);
        flush <= 1'b1; // writebacks and commits still in flight
        @(posedge clk);
        flush <= 1'b0;
        repeat (200) @(posedge clk);
        issue_en <= 1'b0;
        wait_drained();
        repeat (3) @(posedge clk);
        $display("errors: value %0d, other %0d", err_val, err_other);
        if (err_val == 0 && err_other == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* sim/tb_clock.sv */
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;

    always #2 clk = ~clk; // 4 ns period

endmodule

/* source/commit_if.sv */
interface commit_if import ooo_pkg::*; #(
    parameter int TAG_W = 3
);

    logic                  valid; // one pulse per retired entry
    logic [reg_addr_w-1:0] rd;
    logic                  has_rd;
    logic [TAG_W-1:0]      tag;
    logic [xlen-1:0]       data;

    modport rob_mp (output valid, rd, has_rd, tag, data);

    modport regfile_mp (input valid, rd, has_rd, tag, data);

endinterface

/* source/inst_decoder.sv */
module inst_decoder import ooo_pkg::*; (
    input  inst_word_u      instr,
    input  logic [xlen-1:0] pc,
    input  logic            accept,
    rename_if.decoder_mp    rn
);

    op_e             op;
    logic            writes_rd;
    logic            uses_rs2;
    logic [xlen-1:0] imm;

    always_comb begin
        op = OP_ILLEGAL;
        case (instr.r_fmt.opcode)
            opc_op: begin
                if (instr.r_fmt.funct7 == f7_base) begin
                    case (instr.r_fmt.funct3)
                        f3_add:  op = OP_ADD;
                        f3_and:  op = OP_AND;
                        f3_or:   op = OP_OR;
                        default: op = OP_ILLEGAL;
                    endcase
                end else if (instr.r_fmt.funct7 == f7_alt && instr.r_fmt.funct3 == f3_add) begin
                    op = OP_SUB;
                end
            end
            opc_imm: begin
                if (instr.i_fmt.funct3 == f3_add) op = OP_ADDI;
            end
            opc_load: begin
                if (instr.i_fmt.funct3 == f3_word) op = OP_LW;
            end
            opc_store: begin
                if (instr.s_fmt.funct3 == f3_word) op = OP_SW;
            end
            default: op = OP_ILLEGAL;
        endcase
    end

    always_comb begin
        case (op)
            OP_ADDI, OP_LW: imm = {{(xlen - 12){instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
            OP_SW: imm = {{(xlen - 12){instr.s_fmt.imm_hi[6]}},
                          instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
            default: imm = '0;
        endcase
    end

    // writes to x0 need no rename
    assign writes_rd = !(op inside {OP_SW, OP_ILLEGAL}) && instr.r_fmt.rd != '0;
    assign uses_rs2  = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SW};

    assign rn.valid  = accept;
    assign rn.op     = op;
    assign rn.rs1    = (op == OP_ILLEGAL) ? '0 : instr.r_fmt.rs1;
    assign rn.rs2    = uses_rs2 ? instr.r_fmt.rs2 : '0; // i-type has imm here
    assign rn.rd     = writes_rd ? instr.r_fmt.rd : '0;
    assign rn.has_rd = writes_rd;
    assign rn.imm    = imm;
    assign rn.pc     = pc;

endmodule

/* source/ooo_frontend_top.sv */
module ooo_frontend_top import ooo_pkg::*; #(
    parameter int TAG_W = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  instr_valid,
    input  logic [31:0]           instr,
    input  logic [xlen-1:0]       pc,
    output logic                  instr_ready,
    input  logic                  wb_valid,
    input  logic [TAG_W-1:0]      wb_tag,
    input  logic [xlen-1:0]       wb_data,
    output logic                  dispatch_valid,
    output op_e                   dispatch_op,
    output logic [reg_addr_w-1:0] dispatch_rd,
    output logic [TAG_W-1:0]      dispatch_tag,
    output logic [xlen-1:0]       dispatch_imm,
    output logic [xlen-1:0]       dispatch_pc,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data,
    output logic [TAG_W-1:0]      rs1_tag,
    output logic [TAG_W-1:0]      rs2_tag,
    output logic                  commit_valid,
    output logic [reg_addr_w-1:0] commit_rd,
    output logic [xlen-1:0]       commit_data
);

    logic full;
    logic accept;

    rename_if #(.TAG_W(TAG_W)) rn ();
    commit_if #(.TAG_W(TAG_W)) cm ();

    assign accept      = instr_valid && !full;
    assign instr_ready = !full; // only back-pressure source

    inst_decoder u_dec (
        .instr  (instr),
        .pc     (pc),
        .accept (accept),
        .rn     (rn.decoder_mp)
    );

    reorder_buffer #(.TAG_W(TAG_W)) u_rob (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .rn       (rn.rob_mp),
        .wb_valid (wb_valid),
        .wb_tag   (wb_tag),
        .wb_data  (wb_data),
        .full     (full),
        .cm       (cm.rob_mp)
    );

    rename_regfile #(.TAG_W(TAG_W)) u_rf (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .rn             (rn.regfile_mp),
        .cm             (cm.regfile_mp),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_rd    (dispatch_rd),
        .dispatch_tag   (dispatch_tag),
        .dispatch_imm   (dispatch_imm),
        .dispatch_pc    (dispatch_pc),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .rs1_tag        (rs1_tag),
        .rs2_tag        (rs2_tag)
    );

    assign commit_valid = cm.valid;
    assign commit_rd    = cm.rd;
    assign commit_data  = cm.data;

endmodule

/* source/ooo_pkg.sv */
package ooo_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int nregs      = 1 << reg_addr_w;

    localparam logic [6:0] opc_op    = 7'b0110011;
    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;

    localparam logic [2:0] f3_add  = 3'b000; // add, sub, addi
    localparam logic [2:0] f3_word = 3'b010; // lw, sw
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // sub

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_ADDI,
        OP_LW,
        OP_SW,
        OP_ILLEGAL
    } op_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    // same 32 bits, three readings
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } inst_word_u;

endpackage

/* source/rename_if.sv */
interface rename_if import ooo_pkg::*; #(
    parameter int TAG_W = 3
);

    logic                  valid;
    op_e                   op;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic                  has_rd;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       pc;
    logic [TAG_W-1:0]      dest_tag; // from rob

    modport decoder_mp (output valid, op, rs1, rs2, rd, has_rd, imm, pc);

    // rob keeps rd per slot for retirement
    modport rob_mp (input valid, rd, has_rd, output dest_tag);

    modport regfile_mp (input valid, op, rs1, rs2, rd, has_rd, imm, pc, dest_tag);

endinterface

/* source/rename_regfile.sv */
module rename_regfile import ooo_pkg::*; #(
    parameter int TAG_W = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    rename_if.regfile_mp          rn,
    commit_if.regfile_mp          cm,
    output logic                  dispatch_valid,
    output op_e                   dispatch_op,
    output logic [reg_addr_w-1:0] dispatch_rd,
    output logic [TAG_W-1:0]      dispatch_tag,
    output logic [xlen-1:0]       dispatch_imm,
    output logic [xlen-1:0]       dispatch_pc,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data,
    output logic [TAG_W-1:0]      rs1_tag,
    output logic [TAG_W-1:0]      rs2_tag
);

    logic [xlen-1:0]  reg_data [nregs];
    logic [TAG_W-1:0] reg_tag  [nregs];
    logic [TAG_W-1:0] rs1_tag_raw;
    logic [TAG_W-1:0] rs2_tag_raw;
    logic             rs1_byp;
    logic             rs2_byp;

    // sources see the state before this cycle's rename
    assign rs1_tag_raw = reg_tag[rn.rs1];
    assign rs2_tag_raw = reg_tag[rn.rs2];

    // retiring producer forwards its value
    assign rs1_byp = cm.valid && rs1_tag_raw == cm.tag;
    assign rs2_byp = cm.valid && rs2_tag_raw == cm.tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < nregs; i++) begin
                reg_data[i] <= '0;
                reg_tag[i]  <= '0;
            end
        end else if (flush) begin
            for (int i = 0; i < nregs; i++) begin
                reg_tag[i] <= '0; // data survives
            end
        end else begin
            if (cm.valid && cm.has_rd) begin
                reg_data[cm.rd] <= cm.data;
                if (reg_tag[cm.rd] == cm.tag) begin
                    reg_tag[cm.rd] <= '0;
                end
            end
            // a new rename of the same register overrides the clear above
            if (rn.valid && rn.has_rd) begin
                reg_tag[rn.rd] <= rn.dest_tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= rn.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rn.valid) begin
            dispatch_op  <= rn.op;
            dispatch_rd  <= rn.rd;
            dispatch_tag <= rn.dest_tag;
            dispatch_imm <= rn.imm;
            dispatch_pc  <= rn.pc;
            rs1_data     <= rs1_byp ? cm.data : reg_data[rn.rs1];
            rs2_data     <= rs2_byp ? cm.data : reg_data[rn.rs2];
            rs1_tag      <= rs1_byp ? '0 : rs1_tag_raw;
            rs2_tag      <= rs2_byp ? '0 : rs2_tag_raw;
        end
    end

    // x0 is never renamed, so nothing may retire into it
    a_no_x0_commit: assert property (@(posedge clk) disable iff (rst)
        cm.valid |-> !(cm.has_rd && cm.rd == '0))
        else $error("commit into x0 with has_rd");

endmodule

/* source/reorder_buffer.sv */
module reorder_buffer import ooo_pkg::*; #(
    parameter int TAG_W = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    rename_if.rob_mp         rn,
    input  logic             wb_valid,
    input  logic [TAG_W-1:0] wb_tag,
    input  logic [xlen-1:0]  wb_data,
    output logic             full,
    commit_if.rob_mp         cm
);

    localparam int ROB_DEPTH = 2 ** TAG_W - 1; // tag 0 is reserved

    logic [reg_addr_w-1:0] slot_rd     [ROB_DEPTH];
    logic                  slot_has_rd [ROB_DEPTH];
    logic [xlen-1:0]       slot_data   [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]  slot_done;
    logic [TAG_W-1:0]      head;
    logic [TAG_W-1:0]      tail;
    logic [TAG_W-1:0]      count;
    logic [TAG_W-1:0]      wb_idx;
    logic [TAG_W-1:0]      wb_ofs;
    logic                  wb_hit;
    logic                  retire;

    function automatic logic [TAG_W-1:0] ptr_next(input logic [TAG_W-1:0] p);
        return (p == TAG_W'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full        = count == TAG_W'(ROB_DEPTH);
    assign rn.dest_tag = tail + 1'b1; // slot index plus one
    assign retire      = count != '0 && slot_done[head];

    assign wb_hit = wb_valid && wb_tag != '0;
    assign wb_idx = wb_tag - 1'b1;
    // distance of the written slot from head, modulo depth
    assign wb_ofs = (wb_idx >= head) ? wb_idx - head : wb_idx + TAG_W'(ROB_DEPTH) - head;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            slot_done <= '0;
            cm.valid  <= 1'b0;
        end else begin
            cm.valid <= retire;
            if (rn.valid) begin
                tail            <= ptr_next(tail);
                slot_done[tail] <= 1'b0;
            end
            if (wb_hit) begin
                slot_done[wb_idx] <= 1'b1;
            end
            if (retire) begin
                head <= ptr_next(head);
            end
            count <= count + TAG_W'(rn.valid) - TAG_W'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (rn.valid) begin
            slot_rd[tail]     <= rn.rd;
            slot_has_rd[tail] <= rn.has_rd;
        end
        if (wb_hit) begin
            slot_data[wb_idx] <= wb_data;
        end
        if (retire) begin
            cm.rd     <= slot_rd[head];
            cm.has_rd <= slot_has_rd[head];
            cm.tag    <= head + 1'b1;
            cm.data   <= slot_data[head];
        end
    end

    // pointers meet only when empty or full
    a_ptr_count: assert property (@(posedge clk) disable iff (rst)
        (head == tail) == (count == '0 || full))
        else $error("head, tail and count disagree");

    a_wb_live: assert property (@(posedge clk) disable iff (rst || flush)
        wb_valid |-> wb_tag != '0 && wb_ofs < count && !slot_done[wb_idx])
        else $error("writeback to free or completed slot, tag %0d", wb_tag);

endmodule
